// File: build.f
src/vm_pkg.sv
src/cycle_sequencer.sv
src/page_map.sv
src/vmem_control.sv
src/wb_mem_master.sv
src/vm_subsystem.sv
tests/wb_sram_model.sv
tests/vm_subsystem_sva.sv
tests/tb_vm_subsystem.sv

// File: Makefile
# Verilator build and run of the vm subsystem testbench

SIM  = obj_dir/Vtb_vm_subsystem
SRCS = $(shell cat build.f)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) build.f
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module tb_vm_subsystem -f build.f

run: $(SIM)
	./$(SIM) 2>&1 | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then exit 1; fi
	@grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tests/tb_vm_subsystem.sv
// testbench for vm_subsystem: clock, reset, stimulus, reference model, checker and status
`timescale 1ns/1ps
`default_nettype none

module tb_vm_subsystem
   import vm_pkg::*;
;

   localparam int OP_TIMEOUT = 200;
   localparam int RAND_OPS   = 120;

   typedef struct packed {
      mem_op_e  op;
      mem_rsp_t rsp;
      paddr_t   adr;
      word_t    wdata;
   } expect_t;

   typedef struct packed {
      logic   we;
      paddr_t adr;
      word_t  dat;
   } bus_xfer_t;

   logic      clk;
   logic      reset;
   mem_req_t  req;
   map_load_t map_load;
   mem_rsp_t  rsp;
   logic      wb_cyc;
   logic      wb_stb;
   logic      wb_we;
   paddr_t    wb_adr;
   word_t     wb_dat_w;
   word_t     wb_dat_r;
   logic      wb_ack;

   // shadow state for the reference model
   map_entry_t shadow_map [MAP_DEPTH];
   word_t      shadow_mem [paddr_t];
   expect_t    exp_q [$];
   bus_xfer_t  bus_q [$];

   integer     seed = 32'h1f1a;
   int         checks = 0;
   int         mismatches = 0;
   int         timeouts = 0;
   int         cyc_cycles = 0;

   vm_subsystem UUT (
      .clk      (clk),
      .reset    (reset),
      .req      (req),
      .map_load (map_load),
      .rsp      (rsp),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack)
   );

   wb_sram_model #(.SEED(32'h1f1a)) mem (
      .clk      (clk),
      .reset    (reset),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic word_t shadow_word(input paddr_t adr);
      if (shadow_mem.exists(adr))
      begin
         return shadow_mem[adr];
      end
      return {adr[9:0], adr} ^ 32'h5a3c_0f96;
   endfunction

   function automatic paddr_t map_paddr(input vma_t vma);
      return {shadow_map[vma[PAGE_OFS_W +: MAP_IDX_W]].frame, vma[PAGE_OFS_W-1:0]};
   endfunction

   // expected response: reads need access, writes need access and write permit
   function automatic mem_rsp_t expect_rsp(input mem_op_e op, input vma_t vma);
      map_entry_t e;
      mem_rsp_t   r;
      e = shadow_map[vma[PAGE_OFS_W +: MAP_IDX_W]];
      r.done = 1'b1;
      if (op == op_write)
      begin
         r.fault = !(e.access && e.wperm);
      end
      else
      begin
         r.fault = !e.access;
      end
      r.rdata = (r.fault || op == op_write) ? '0 : shadow_word(map_paddr(vma));
      return r;
   endfunction

   task automatic check_rsp(input mem_rsp_t got, input mem_rsp_t exp, input logic with_data);
      checks++;
      if (got.fault !== exp.fault)
      begin
         mismatches++;
         $display("mismatch rsp.fault: got %h expected %h at %0t", got.fault, exp.fault, $time);
      end
      if (with_data && got.rdata !== exp.rdata)
      begin
         mismatches++;
         $display("mismatch rsp.rdata: got %h expected %h at %0t", got.rdata, exp.rdata, $time);
      end
   endtask

   task automatic check_adr(input paddr_t got, input paddr_t exp);
      checks++;
      if (got !== exp)
      begin
         mismatches++;
         $display("mismatch wb_adr: got %h expected %h at %0t", got, exp, $time);
      end
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp)
      begin
         mismatches++;
         $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         mismatches++;
         $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   // bus monitor and response checker
   always @(posedge clk)
   begin : rsp_checker
      expect_t e;
      if (!reset)
      begin
         if (wb_cyc)
         begin
            cyc_cycles++;
         end
         if (wb_cyc && wb_stb && wb_ack)
         begin
            bus_q.push_back({wb_we, wb_adr, wb_dat_w});
         end
         if (rsp.done)
         begin
            if (exp_q.size() == 0)
            begin
               mismatches++;
               $display("done seen with no request outstanding at %0t", $time);
            end
            else
            begin
               e = exp_q.pop_front();
               check_rsp(rsp, e.rsp, e.op != op_write && !e.rsp.fault);
               if (e.rsp.fault)
               begin
                  checks++;
                  if (cyc_cycles != 0)
                  begin
                     mismatches++;
                     $display("bus cycle started for a denied access at %0t", $time);
                  end
               end
               else if (bus_q.size() != 1)
               begin
                  mismatches++;
                  $display("expected one bus cycle, saw %0d at %0t", bus_q.size(), $time);
               end
               else
               begin
                  check_adr(bus_q[0].adr, e.adr);
                  check_bit("wb_we", bus_q[0].we, e.op == op_write);
                  if (e.op == op_write)
                  begin
                     check_word("wb_dat_w", bus_q[0].dat, e.wdata);
                  end
               end
            end
            bus_q.delete();
            cyc_cycles = 0;
         end
      end
   end

   task automatic end_run();
      $display("checks %0d, mismatches %0d, timeouts %0d, unanswered %0d",
               checks, mismatches, timeouts, exp_q.size());
      if (mismatches == 0 && timeouts == 0 && exp_q.size() == 0 && checks > 0)
      begin
         $display("STATUS: PASS");
      end
      else
      begin
         $display("STATUS: FAIL");
      end
      $finish;
   endtask

   // single-cycle map write, called on a falling edge
   task automatic load_map(input map_idx_t idx, input logic acc, input logic wp,
                           input frame_t fr);
      map_load.en           = 1'b1;
      map_load.idx          = idx;
      map_load.entry.access = acc;
      map_load.entry.wperm  = wp;
      map_load.entry.frame  = fr;
      shadow_map[idx]       = {acc, wp, fr};
      @(negedge clk);
      map_load.en = 1'b0;
   endtask

   // hold the request until done, then idle for a cycle
   task automatic do_op(input mem_op_e op, input vma_t vma, input word_t wdata);
      expect_t e;
      int      waited;
      e.op    = op;
      e.rsp   = expect_rsp(op, vma);
      e.adr   = map_paddr(vma);
      e.wdata = wdata;
      exp_q.push_back(e);
      req.op    = op;
      req.vma   = vma;
      req.wdata = wdata;
      waited    = 0;
      do
      begin
         @(negedge clk);
         waited++;
      end
      while (!rsp.done && waited < OP_TIMEOUT);
      if (!rsp.done)
      begin
         timeouts++;
         $display("no done for %s at vma %h after %0d cycles", op.name(), vma, waited);
         end_run();
      end
      else
      begin
         req.op = op_none;
         if (op == op_write && !e.rsp.fault)
         begin
            shadow_mem[e.adr] = wdata;
         end
         @(negedge clk);
      end
   endtask

   initial
   begin : stimulus
      logic [31:0] rnd;
      vma_t        vma;
      word_t       wdata;
      reset    = 1'b1;
      req      = '0;
      map_load = '0;
      for (int i = 0; i < MAP_DEPTH; i++)
      begin
         shadow_map[i] = '0;
      end
      repeat (16) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);

      // nothing mapped yet
      do_op(op_read, 24'h000105, '0);

      // writable page, then read back by read and ifetch
      load_map(6'd1, 1'b1, 1'b1, 14'h0123);
      do_op(op_write, 24'h000105, 32'hcafe_0105);
      do_op(op_read, 24'h000105, '0);
      do_op(op_ifetch, 24'h000105, '0);
      do_op(op_ifetch, 24'h3c0105, '0);
      do_op(op_read, 24'h0001f0, '0);

      // write-protected page keeps its old data
      load_map(6'd2, 1'b1, 1'b1, 14'h0456);
      do_op(op_write, 24'h000210, 32'h1234_5678);
      load_map(6'd2, 1'b1, 1'b0, 14'h0456);
      do_op(op_write, 24'h000210, 32'hdead_beef);
      do_op(op_read, 24'h000210, '0);

      // random mix over eight pages and sixteen words per page
      for (int i = 0; i < 8; i++)
      begin
         load_map(map_idx_t'(i), 1'b1, 1'b1, {12'h0a5, i[1:0]});
      end
      for (int n = 0; n < RAND_OPS; n++)
      begin
         rnd   = $random(seed);
         wdata = $random(seed);
         vma   = {rnd[31:22], 3'b000, rnd[2:0], 4'h0, rnd[7:4]};
         case (rnd[10:8])
            3'd0:
            begin
               load_map({3'b000, rnd[2:0]}, rnd[11] | rnd[12], rnd[13], {12'h0a5, rnd[15:14]});
            end
            3'd1, 3'd2:
            begin
               do_op(op_write, vma, wdata);
            end
            3'd3:
            begin
               do_op(op_ifetch, vma, '0);
            end
            default:
            begin
               do_op(op_read, vma, '0);
            end
         endcase
      end
      end_run();
   end

endmodule

`default_nettype wire

// File: tests/vm_subsystem_sva.sv
// bound assertions on the controller pipeline and the Wishbone strobe timing
`timescale 1ns/1ps
`default_nettype none

module vm_subsystem_sva
(
   input wire logic clk,
   input wire logic reset,
   input wire logic start,
   input wire logic check,
   input wire logic busy,
   input wire logic fault,
   input wire logic rdcyc,
   input wire logic wrcyc,
   input wire logic wb_stb,
   input wire logic wb_ack
);

   // map result checked one clock after the lookup starts, then either running or denied
   assert property (@(posedge clk) disable iff (reset) start |=> check ##1 (busy ^ fault))
      else $error("check did not follow start with a permit decision");

   // strobe stays up until the slave acknowledges
   assert property (@(posedge clk) disable iff (reset) (wb_stb && !wb_ack) |=> wb_stb)
      else $error("wb_stb dropped before wb_ack");

   assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_stb)
      else $error("wb_stb still high after wb_ack");

   // a bus cycle is either a read or a write
   assert property (@(posedge clk) disable iff (reset)
      !(rdcyc && wrcyc) && (!wb_stb || rdcyc || wrcyc))
      else $error("cycle type is not exactly one of read and write");

endmodule

bind vm_subsystem vm_subsystem_sva u_sva (
   .clk    (clk),
   .reset  (reset),
   .start  (u_ctl.start),
   .check  (u_ctl.check),
   .busy   (u_ctl.busy),
   .fault  (fault),
   .rdcyc  (rdcyc),
   .wrcyc  (wrcyc),
   .wb_stb (wb_stb),
   .wb_ack (wb_ack)
);

`default_nettype wire

// File: tests/wb_sram_model.sv
// Wishbone classic memory model with a random acknowledge delay
`timescale 1ns/1ps
`default_nettype none

module wb_sram_model
   import vm_pkg::*;
#(
   parameter int SEED = 32'h1f1a
)
(
   input  wire logic   clk,
   input  wire logic   reset,
   input  wire logic   wb_cyc,
   input  wire logic   wb_stb,
   input  wire logic   wb_we,
   input  wire paddr_t wb_adr,
   input  wire word_t  wb_dat_w,
   output word_t       wb_dat_r,
   output logic        wb_ack
);

   word_t  mem [paddr_t];
   integer seed = SEED;
   int     delay = 0;
   logic   armed = 1'b0;
   logic   ack_q = 1'b0;
   word_t  dat_q = '0;

   // unwritten words read back as a pattern built from the whole address
   function automatic word_t fill_word(input paddr_t adr);
      return {adr[9:0], adr} ^ 32'h5a3c_0f96;
   endfunction

   always @(negedge clk)
   begin
      if (reset)
      begin
         ack_q <= 1'b0;
         armed = 1'b0;
      end
      else if (ack_q)
      begin
         // single-cycle ack
         ack_q <= 1'b0;
      end
      else if (wb_cyc && wb_stb)
      begin
         if (!armed)
         begin
            delay = $unsigned($random(seed)) % 5;
            armed = 1'b1;
         end
         if (delay == 0)
         begin
            ack_q <= 1'b1;
            armed = 1'b0;
            if (wb_we)
            begin
               mem[wb_adr] = wb_dat_w;
            end
            else if (mem.exists(wb_adr))
            begin
               dat_q <= mem[wb_adr];
            end
            else
            begin
               dat_q <= fill_word(wb_adr);
            end
         end
         else
         begin
            delay--;
         end
      end
   end

   assign wb_ack   = ack_q;
   assign wb_dat_r = dat_q;

endmodule

`default_nettype wire

// File: src/vm_subsystem.sv
// vm_subsystem: top level joining sequencer, page map, controller and bus master
`timescale 1ns/1ps
`default_nettype none

module vm_subsystem
   import vm_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      reset,
   input  wire mem_req_t  req,
   input  wire map_load_t map_load,
   output mem_rsp_t       rsp,
   output logic           wb_cyc,
   output logic           wb_stb,
   output logic           wb_we,
   output paddr_t         wb_adr,
   output word_t          wb_dat_w,
   input  wire word_t     wb_dat_r,
   input  wire logic      wb_ack
);

   cycle_state_e state;
   map_entry_t   entry;
   paddr_t       paddr;
   word_t        rdata;
   logic         waiting;
   logic         memrq;
   logic         rdcyc;
   logic         wrcyc;
   logic         memack;
   logic         done;
   logic         fault;

   cycle_sequencer u_seq (
      .clk     (clk),
      .reset   (reset),
      .waiting (waiting),
      .state   (state)
   );

   page_map u_map (
      .clk      (clk),
      .reset    (reset),
      .map_load (map_load),
      .vma      (req.vma),
      .entry    (entry)
   );

   // frame from the map, offset from the vma
   assign paddr = {entry.frame, req.vma[PAGE_OFS_W-1:0]};

   vmem_control u_ctl (
      .clk     (clk),
      .reset   (reset),
      .state   (state),
      .op      (req.op),
      .entry   (entry),
      .memack  (memack),
      .memrq   (memrq),
      .rdcyc   (rdcyc),
      .wrcyc   (wrcyc),
      .waiting (waiting),
      .done    (done),
      .fault   (fault)
   );

   wb_mem_master u_wb (
      .clk      (clk),
      .reset    (reset),
      .memrq    (memrq),
      .rdcyc    (rdcyc),
      .wrcyc    (wrcyc),
      .paddr    (paddr),
      .wdata    (req.wdata),
      .rdata    (rdata),
      .memack   (memack),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack)
   );

   assign rsp.done  = done;
   assign rsp.fault = fault;
   assign rsp.rdata = rdata;

endmodule

`default_nettype wire

// File: src/wb_mem_master.sv
// wb_mem_master: Wishbone classic master, one bus cycle per memory request
`timescale 1ns/1ps
`default_nettype none

module wb_mem_master
   import vm_pkg::*;
(
   input  wire logic   clk,
   input  wire logic   reset,
   input  wire logic   memrq,
   input  wire logic   rdcyc,
   input  wire logic   wrcyc,
   input  wire paddr_t paddr,
   input  wire word_t  wdata,
   output word_t       rdata,
   output logic        memack,
   output logic        wb_cyc,
   output logic        wb_stb,
   output logic        wb_we,
   output paddr_t      wb_adr,
   output word_t       wb_dat_w,
   input  wire word_t  wb_dat_r,
   input  wire logic   wb_ack
);

   typedef enum logic {
      bus_idle   = 1'b0,
      bus_active = 1'b1
   } bus_state_e;

   bus_state_e bus_q;
   paddr_t     adr_q;
   word_t      dat_q;
   word_t      rdata_q;

   // memrq is still high while memack is out, don't restart on it
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         bus_q  <= bus_idle;
         memack <= 1'b0;
      end
      else
      begin
         memack <= 1'b0;
         case (bus_q)
            bus_idle:
            begin
               if (memrq && !memack)
               begin
                  bus_q <= bus_active;
               end
            end
            bus_active:
            begin
               if (wb_ack)
               begin
                  bus_q  <= bus_idle;
                  memack <= 1'b1;
               end
            end
            default:
            begin
               bus_q <= bus_idle;
            end
         endcase
      end
   end

   // address and data held for the whole cycle
   always_ff @(posedge clk)
   begin
      if (bus_q == bus_idle && memrq)
      begin
         adr_q <= paddr;
         dat_q <= wdata;
      end
      if (bus_q == bus_active && wb_ack && rdcyc)
      begin
         rdata_q <= wb_dat_r;
      end
   end

   assign wb_cyc   = (bus_q == bus_active);
   assign wb_stb   = (bus_q == bus_active);
   // wrcyc is latched on the same edge the cycle opens
   assign wb_we    = (bus_q == bus_active) & wrcyc;
   assign wb_adr   = adr_q;
   assign wb_dat_w = dat_q;
   assign rdata    = rdata_q;

endmodule

`default_nettype wire

// File: src/vmem_control.sv
// vmem_control: prepare/start/check pipeline, permission test, busy and cycle type
`timescale 1ns/1ps
`default_nettype none

module vmem_control
   import vm_pkg::*;
(
   input  wire logic         clk,
   input  wire logic         reset,
   input  wire cycle_state_e state,
   input  wire mem_op_e      op,
   input  wire map_entry_t   entry,
   input  wire logic         memack,
   output logic              memrq,
   output logic              rdcyc,
   output logic              wrcyc,
   output logic              waiting,
   output logic              done,
   output logic              fault
);

   logic prepare;
   logic start;
   logic check;
   logic busy;
   logic pending;
   logic deny;

   logic op_valid;
   logic is_write;
   logic launch;
   logic pfr;
   logic pfw;
   logic permit;
   logic mfinish;

   assign op_valid = (op != op_none);
   assign is_write = (op == op_write);

   // new ops only enter in an alu or write phase
   assign launch = op_valid & ~pending & ((state == st_alu) | (state == st_write));

   // held until the host drops op after done
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         pending <= 1'b0;
      end
      else if (launch)
      begin
         pending <= 1'b1;
      end
      else if (!op_valid)
      begin
         pending <= 1'b0;
      end
   end

   // prepare, then start the map lookup, then check it
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         prepare <= 1'b0;
         start   <= 1'b0;
         check   <= 1'b0;
      end
      else
      begin
         prepare <= launch;
         start   <= prepare & (state != st_alu);
         check   <= start;
      end
   end

   // read needs access, write needs access and write permit
   assign pfr    = entry.access & ~is_write;
   assign pfw    = entry.access & entry.wperm & is_write;
   assign permit = pfr | pfw;

   assign mfinish = memack;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy  <= 1'b0;
         rdcyc <= 1'b0;
         wrcyc <= 1'b0;
         deny  <= 1'b0;
      end
      else
      begin
         deny <= check & ~permit;
         if (mfinish)
         begin
            busy  <= 1'b0;
            rdcyc <= 1'b0;
            wrcyc <= 1'b0;
         end
         else if (check && permit)
         begin
            // cycle type decided here, ifetch counts as a read
            busy  <= 1'b1;
            rdcyc <= ~is_write;
            wrcyc <= is_write;
         end
      end
   end

   assign memrq   = busy | (check & ~start & permit);
   assign waiting = memrq & busy;

   // denied ops finish one cycle after check, others on memack
   assign done  = deny | memack;
   assign fault = deny;

endmodule

`default_nettype wire

// File: src/page_map.sv
// page_map: writable 64-entry page map with combinational lookup
`timescale 1ns/1ps
`default_nettype none

module page_map
   import vm_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      reset,
   input  wire map_load_t map_load,
   input  wire vma_t      vma,
   output map_entry_t     entry
);

   // access bit of every entry
   logic [MAP_DEPTH-1:0] access_q;

   // write-permit and frame of every entry
   logic                 wperm_mem [MAP_DEPTH];
   frame_t               frame_mem [MAP_DEPTH];

   map_idx_t             idx;

   // index is the vma bits just above the word offset
   assign idx = vma[PAGE_OFS_W +: MAP_IDX_W];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         access_q <= '0;
      end
      else if (map_load.en)
      begin
         access_q[map_load.idx] <= map_load.entry.access;
      end
   end

   always_ff @(posedge clk)
   begin
      if (map_load.en)
      begin
         wperm_mem[map_load.idx] <= map_load.entry.wperm;
         frame_mem[map_load.idx] <= map_load.entry.frame;
      end
   end

   // lookup straight off the held vma
   always_comb
   begin
      entry.access = access_q[idx];
      entry.wperm  = wperm_mem[idx];
      entry.frame  = frame_mem[idx];
   end

endmodule

`default_nettype wire

// File: src/cycle_sequencer.sv
// cycle_sequencer: four-phase machine-cycle FSM with a hold input
`timescale 1ns/1ps
`default_nettype none

module cycle_sequencer
   import vm_pkg::*;
(
   input  wire logic   clk,
   input  wire logic   reset,
   input  wire logic   waiting,
   output cycle_state_e state
);

   cycle_state_e state_q;
   cycle_state_e state_next;

   // alu -> write -> fetch -> prefetch, then around again
   always_comb
   begin
      state_next = state_q;
      if (!waiting)
      begin
         case (state_q)
            st_alu:
            begin
               state_next = st_write;
            end
            st_write:
            begin
               state_next = st_fetch;
            end
            st_fetch:
            begin
               state_next = st_prefetch;
            end
            st_prefetch:
            begin
               state_next = st_alu;
            end
            default:
            begin
               state_next = st_alu;
            end
         endcase
      end
   end

   // frozen in place while memory holds us off
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state_q <= st_alu;
      end
      else
      begin
         state_q <= state_next;
      end
   end

   assign state = state_q;

endmodule

`default_nettype wire

// File: src/vm_pkg.sv
// widths, typedefs, enums and the request, response and map structs of the vm path
`default_nettype none

package vm_pkg;

   // address and data widths
   localparam int VMA_W      = 24;
   localparam int PAGE_OFS_W = 8;
   localparam int MAP_IDX_W  = 6;
   localparam int FRAME_W    = 14;
   localparam int PADDR_W    = 22;
   localparam int WORD_W     = 32;

   // number of second-level map entries
   localparam int MAP_DEPTH  = 2 ** MAP_IDX_W;

   typedef logic [VMA_W-1:0]     vma_t;
   typedef logic [PADDR_W-1:0]   paddr_t;
   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [FRAME_W-1:0]   frame_t;
   typedef logic [MAP_IDX_W-1:0] map_idx_t;

   typedef enum logic [1:0] {
      op_none   = 2'd0,
      op_read   = 2'd1,
      op_write  = 2'd2,
      op_ifetch = 2'd3
   } mem_op_e;

   // machine-cycle phases, in rotation order
   typedef enum logic [1:0] {
      st_alu      = 2'd0,
      st_write    = 2'd1,
      st_fetch    = 2'd2,
      st_prefetch = 2'd3
   } cycle_state_e;

   typedef struct packed {
      logic   access;
      logic   wperm;
      frame_t frame;
   } map_entry_t;

   typedef struct packed {
      logic       en;
      map_idx_t   idx;
      map_entry_t entry;
   } map_load_t;

   typedef struct packed {
      mem_op_e op;
      vma_t    vma;
      word_t   wdata;
   } mem_req_t;

   typedef struct packed {
      logic  done;
      logic  fault;
      word_t rdata;
   } mem_rsp_t;

endpackage

`default_nettype wire
